// File: bus_pkg.sv
package bus_pkg;

	localparam int WB_ADR_BITS = 4;
	localparam int WB_DAT_BITS = 16;

	// wishbone classic, master side
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [WB_ADR_BITS-1:0] adr;
		logic [WB_DAT_BITS-1:0] dat_w;
	} wb_req_t;

	typedef struct packed {
		logic ack;
		logic [WB_DAT_BITS-1:0] dat_r;
	} wb_rsp_t;

	// register map, 5..7 are unused and read 0
	typedef enum logic [WB_ADR_BITS-1:0] {
		MODE    = 4'd0,
		START   = 4'd1,
		STATUS  = 4'd2,
		HEIGHT  = 4'd3,
		COLOR   = 4'd4,
		PHASE0  = 4'd8,
		PHASE1  = 4'd9,
		PHASE2  = 4'd10,
		PHASE3  = 4'd11,
		DPHASE0 = 4'd12,
		DPHASE1 = 4'd13,
		DPHASE2 = 4'd14,
		DPHASE3 = 4'd15
	} reg_addr_e;

endpackage

// File: height_accumulator.sv
`timescale 1ns/100ps

module height_accumulator (
	input  logic clk,
	input  logic reset,
	input  render_pkg::wave_sample_t sample,
	input  logic [render_pkg::WAVE_INDEX_BITS-1:0] wave_index,
	input  logic step_en,
	input  logic commit,
	output logic [render_pkg::ZG_BITS-1:0] height,
	output logic [render_pkg::SHADE_BITS-1:0] shade,
	output render_pkg::color_t color,
	output logic result_valid
);

	localparam int ZG_BITS = render_pkg::ZG_BITS;
	localparam int CH_BITS = render_pkg::CHANNEL_BITS;

	logic signed [ZG_BITS-1:0] y_ext;
	logic signed [ZG_BITS-1:0] delta;
	logic [ZG_BITS-1:0] height_acc;
	logic [ZG_BITS-1:0] height_sum;
	logic [render_pkg::SHADE_BITS-1:0] shade_acc;
	logic [render_pkg::SHADE_BITS-1:0] shade_sum;
	logic [CH_BITS:0] l;
	logic [CH_BITS-1:0] r0;

	// later waves contribute less, one bit per wave index
	assign y_ext = sample.y;
	assign delta = y_ext >>> wave_index;

	// the first wave starts from mid range
	assign height_sum = (wave_index == '0 ? ZG_BITS'(1 << (ZG_BITS - 1)) : height_acc)
		+ delta;
	assign shade_sum = (wave_index == '0 ? '0 : shade_acc) + sample.shade;

	always_ff @(posedge clk) begin
		if (step_en) begin
			height_acc <= height_sum;
			shade_acc <= shade_sum;
		end
	end

	// results hold until the next pass commits
	always_ff @(posedge clk) begin
		if (reset) begin
			height <= '0;
			shade <= '0;
			result_valid <= 1'b0;
		end else if (commit) begin
			height <= height_acc;
			shade <= shade_acc;
			result_valid <= 1'b1;
		end
	end

	// ======================================================================
	// colour shading
	// ======================================================================

	// low ground is bright, red only shows in the brightest half
	assign l = ~height[ZG_BITS-1 -: CH_BITS+1];
	assign r0 = l[CH_BITS] ? l[CH_BITS-1:0] : '0;
	assign color.g = shade[render_pkg::SHADE_BITS-1 -: CH_BITS];
	assign color.r = (r0 < color.g) ? r0 : color.g;
	assign color.b = ~height[ZG_BITS-1 -: CH_BITS];

endmodule

// File: phase_bank.sv
`timescale 1ns/100ps

module phase_bank #(
	parameter int NUM_WAVES = 3
) (
	input  logic clk,
	input  logic reset,
	input  render_pkg::phase_wr_t phase_wr,
	input  render_pkg::dphase_wr_t dphase_wr,
	input  logic [render_pkg::WAVE_INDEX_BITS-1:0] wave_index,
	input  logic step_en,
	output render_pkg::phase_t curr_phase,
	output render_pkg::phase_t [NUM_WAVES-1:0] phases,
	output render_pkg::dphase_t [NUM_WAVES-1:0] dphases
);

	localparam int EXT_BITS = render_pkg::PHASE_BITS - render_pkg::DPHASE_BITS;

	render_pkg::dphase_t curr_dphase;
	render_pkg::phase_t dphase_ext;
	render_pkg::phase_t next_phase;

	// select the active wave, indices past the last wave read as zero
	always_comb begin
		curr_phase = '0;
		curr_dphase = '0;
		for (int i = 0; i < NUM_WAVES; i++) begin
			if (wave_index == i) begin
				curr_phase = phases[i];
				curr_dphase = dphases[i];
			end
		end
	end

	// signed step, wraps modulo 2^16
	assign dphase_ext = {{EXT_BITS{curr_dphase[render_pkg::DPHASE_BITS-1]}}, curr_dphase};
	assign next_phase = curr_phase + dphase_ext;

	always_ff @(posedge clk) begin
		if (reset) begin
			phases <= '0;
			dphases <= '0;
		end else begin
			for (int i = 0; i < NUM_WAVES; i++) begin
				// host writes are held off while busy, so the step wins
				if (step_en && wave_index == i)
					phases[i] <= next_phase;
				else if (phase_wr.we && phase_wr.wave == i)
					phases[i] <= phase_wr.data;
				if (dphase_wr.we && dphase_wr.wave == i)
					dphases[i] <= dphase_wr.data;
			end
		end
	end

endmodule

// File: render_patterns.txt
# columns (hex): mode p0 p1 p2 d0 d1 d2 steps
# mode bit0 sharp, bit1 semi_sharp; increments are 12-bit signed
0 0000 0000 0000 000 000 000 1
0 4000 8000 c000 100 200 300 3
0 1234 5678 9abc 7ff 800 001 4
1 0000 4000 8000 040 fc0 123 3
1 f000 3c00 a5a5 abc 555 0f0 2
3 0000 4000 8000 040 fc0 123 3
3 c3c3 7e7e 1818 fff 001 800 4
2 2468 ace0 1357 321 def 654 2
0 ffff 0001 8000 080 f80 400 5
1 7fff 8001 3fff 010 ff0 7f0 3
3 e000 6000 2000 c00 400 200 2

// File: render_pkg.sv
package render_pkg;

	// ======================================================================
	// data path widths
	// ======================================================================

	localparam int PHASE_BITS = 16;
	// signed per-step increment, sign-extended onto the phase
	localparam int DPHASE_BITS = 12;
	localparam int WAVE_INDEX_BITS = 2;

	// sine table: 4 index bits with 2 quadrant bits above them
	localparam int SINE_IN_BITS = 4;
	localparam int SINE_OUT_BITS = 6;
	localparam int MAP_IN_BITS = SINE_IN_BITS + 2;

	localparam int ZG_BITS = 10;
	localparam int SHADE_BITS = 4;
	localparam int SHADE_TERM_BITS = 2;
	localparam int CHANNEL_BITS = 3;

	// ======================================================================
	// types
	// ======================================================================

	typedef logic [PHASE_BITS-1:0] phase_t;
	typedef logic signed [DPHASE_BITS-1:0] dphase_t;

	// one wave's contribution, sample is one bit wider than the table entry
	typedef struct packed {
		logic signed [SINE_OUT_BITS:0] y;
		logic [SHADE_TERM_BITS-1:0] shade;
	} wave_sample_t;

	typedef struct packed {
		logic [CHANNEL_BITS-1:0] r;
		logic [CHANNEL_BITS-1:0] g;
		logic [CHANNEL_BITS-1:0] b;
	} color_t;

	// sharp sits in bit 0
	typedef struct packed {
		logic semi_sharp;
		logic sharp;
	} sine_mode_t;

	// host writes into the phase bank
	typedef struct packed {
		logic we;
		logic [WAVE_INDEX_BITS-1:0] wave;
		phase_t data;
	} phase_wr_t;

	typedef struct packed {
		logic we;
		logic [WAVE_INDEX_BITS-1:0] wave;
		dphase_t data;
	} dphase_wr_t;

	typedef enum logic [1:0] {
		IDLE,
		EVAL,
		COMMIT
	} seq_state_e;

endpackage

// File: render_sequencer.sv
`timescale 1ns/100ps

module render_sequencer (
	input  logic clk,
	input  logic reset,
	input  logic start,
	input  logic last,
	output logic busy,
	output logic step_en,
	output logic commit
);

	render_pkg::seq_state_e state;
	render_pkg::seq_state_e next_state;

	always_comb begin
		next_state = state;
		case (state)
			render_pkg::IDLE: begin
				if (start)
					next_state = render_pkg::EVAL;
			end
			// one wave per cycle until the last one has been stepped
			render_pkg::EVAL: begin
				if (step_en && last)
					next_state = render_pkg::COMMIT;
			end
			render_pkg::COMMIT: begin
				next_state = render_pkg::IDLE;
			end
			default: begin
				next_state = render_pkg::IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= render_pkg::IDLE;
		end else begin
			state <= next_state;
		end
	end

	assign step_en = (state == render_pkg::EVAL);
	assign commit = (state == render_pkg::COMMIT);
	assign busy = (state != render_pkg::IDLE);

endmodule

// File: sine_wave_map.sv
`timescale 1ns/100ps

module sine_wave_map (
	input  render_pkg::phase_t phase,
	input  render_pkg::sine_mode_t mode,
	output render_pkg::wave_sample_t sample
);

	localparam int IN_BITS = render_pkg::SINE_IN_BITS;
	localparam int OUT_BITS = render_pkg::SINE_OUT_BITS;

	logic [render_pkg::MAP_IN_BITS-1:0] map_in;
	logic q1;
	logic q0;
	logic use_sharp;
	logic [IN_BITS-1:0] idx;
	logic [IN_BITS-1:0] tab_x;
	logic [OUT_BITS-1:0] tab_y;
	logic [OUT_BITS:0] y_bits;

	// top phase bits: two quadrant bits, then the table index
	assign map_in = phase[render_pkg::PHASE_BITS-1 -: render_pkg::MAP_IN_BITS];
	assign q1 = map_in[IN_BITS+1];
	assign q0 = map_in[IN_BITS];
	assign idx = map_in[IN_BITS-1:0];

	// semi sharp only sharpens the lower half wave
	assign use_sharp = mode.sharp && (!mode.semi_sharp || q1);

	// fold the index back for falling quarters
	assign tab_x = idx ^ {IN_BITS{q0 ^ use_sharp}};

	// round(63 * sin((k + 0.5) * pi / 32))
	always_comb begin
		case (tab_x)
			4'd0:  tab_y = 6'd3;
			4'd1:  tab_y = 6'd9;
			4'd2:  tab_y = 6'd15;
			4'd3:  tab_y = 6'd21;
			4'd4:  tab_y = 6'd27;
			4'd5:  tab_y = 6'd32;
			4'd6:  tab_y = 6'd38;
			4'd7:  tab_y = 6'd42;
			4'd8:  tab_y = 6'd47;
			4'd9:  tab_y = 6'd51;
			4'd10: tab_y = 6'd54;
			4'd11: tab_y = 6'd57;
			4'd12: tab_y = 6'd59;
			4'd13: tab_y = 6'd61;
			4'd14: tab_y = 6'd62;
			default: tab_y = 6'd63;
		endcase
	end

	// q1 is the sign; the magnitude bits flip for the negative half
	assign y_bits = {q1, tab_y ^ {OUT_BITS{q1 ^ use_sharp}}};

	// rough cosine from the folded index
	assign sample = '{
		y: y_bits,
		shade: ~tab_x[IN_BITS-1 -: render_pkg::SHADE_TERM_BITS]
	};

endmodule

// File: src.f
render_pkg.sv
bus_pkg.sv
sine_wave_map.sv
wave_counter.sv
render_sequencer.sv
phase_bank.sv
height_accumulator.sv
wb_register_file.sv
wave_renderer_top.sv
tb_wave_renderer.sv

// File: tb_wave_renderer.sv
`timescale 1ns/100ps

module tb_wave_renderer;

	localparam int NUM_WAVES = 3;
	localparam int ACK_TIMEOUT = 50;
	localparam int BUSY_TIMEOUT = 200;
	localparam int RANDOM_LINES = 20;

	logic clk;
	logic reset;
	bus_pkg::wb_req_t wb_req;
	bus_pkg::wb_rsp_t wb_rsp;

	// reference model state, phases advance as the DUT steps them
	render_pkg::phase_t m_phase [NUM_WAVES];
	render_pkg::dphase_t m_dphase [NUM_WAVES];
	render_pkg::sine_mode_t m_mode;
	logic [render_pkg::ZG_BITS-1:0] exp_height;
	logic [render_pkg::SHADE_BITS-1:0] exp_shade;
	logic [7:0] exp_count;
	integer seed;

	wave_renderer_top #(.NUM_WAVES(NUM_WAVES)) UUT (
		.clk(clk), .reset(reset), .wb_req(wb_req), .wb_rsp(wb_rsp)
	);

	always #5 clk = ~clk;

	// ======================================================================
	// failure reporting and compare tasks
	// ======================================================================

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("Test FAILED");
		$fatal(1);
	endtask

	task automatic check_height(input string name,
		input logic [render_pkg::ZG_BITS-1:0] expected,
		input logic [render_pkg::ZG_BITS-1:0] actual);
		if (actual !== expected)
			report_failure($sformatf("Mismatch %s: expected %h, actual %h",
				name, expected, actual));
	endtask

	task automatic check_color(input string name, input render_pkg::color_t expected,
		input render_pkg::color_t actual);
		if (actual !== expected)
			report_failure($sformatf("Mismatch %s: expected %h, actual %h",
				name, expected, actual));
	endtask

	task automatic check_shade(input string name,
		input logic [render_pkg::SHADE_BITS-1:0] expected,
		input logic [render_pkg::SHADE_BITS-1:0] actual);
		if (actual !== expected)
			report_failure($sformatf("Mismatch %s: expected %h, actual %h",
				name, expected, actual));
	endtask

	task automatic check_phase(input string name, input render_pkg::phase_t expected,
		input render_pkg::phase_t actual);
		if (actual !== expected)
			report_failure($sformatf("Mismatch %s: expected %h, actual %h",
				name, expected, actual));
	endtask

	task automatic check_count(input string name, input logic [7:0] expected,
		input logic [7:0] actual);
		if (actual !== expected)
			report_failure($sformatf("Mismatch %s: expected %h, actual %h",
				name, expected, actual));
	endtask

	// raw register readback
	task automatic check_word(input string name,
		input logic [bus_pkg::WB_DAT_BITS-1:0] expected,
		input logic [bus_pkg::WB_DAT_BITS-1:0] actual);
		if (actual !== expected)
			report_failure($sformatf("Mismatch %s: expected %h, actual %h",
				name, expected, actual));
	endtask

	// ======================================================================
	// wishbone classic master
	// ======================================================================

	// called 1 ns after an edge, returns 1 ns after an edge
	task automatic bus_write(input bus_pkg::reg_addr_e adr, input logic [15:0] data);
		int cycles;
		cycles = 0;
		wb_req = '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: adr, dat_w: data};
		@(posedge clk);
		#1;
		while (!wb_rsp.ack) begin
			if (cycles >= ACK_TIMEOUT) begin
				report_failure($sformatf("no ack for write to address %0d", adr));
			end else begin
				cycles++;
				@(posedge clk);
				#1;
			end
		end
		wb_req = '0;
		// stb stays low for one idle cycle
		@(posedge clk);
		#1;
	endtask

	task automatic bus_read(input bus_pkg::reg_addr_e adr, output logic [15:0] data);
		int cycles;
		cycles = 0;
		wb_req = '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: adr, dat_w: 16'h0};
		@(posedge clk);
		#1;
		while (!wb_rsp.ack) begin
			if (cycles >= ACK_TIMEOUT) begin
				report_failure($sformatf("no ack for read of address %0d", adr));
			end else begin
				cycles++;
				@(posedge clk);
				#1;
			end
		end
		data = wb_rsp.dat_r;
		wb_req = '0;
		@(posedge clk);
		#1;
	endtask

	// poll STATUS until busy drops
	task automatic wait_idle(output logic [15:0] status);
		int polls;
		polls = 0;
		bus_read(bus_pkg::STATUS, status);
		while (status[0]) begin
			if (polls >= BUSY_TIMEOUT) begin
				report_failure("busy did not clear after a START write");
			end else begin
				polls++;
				bus_read(bus_pkg::STATUS, status);
			end
		end
	endtask

	// ======================================================================
	// reference model
	// ======================================================================

	// quarter-wave entry, nearest integer
	function automatic int sine_entry(input int k);
		return $rtoi(63.0 * $sin((k + 0.5) * 3.141592653589793 / 32.0) + 0.5);
	endfunction

	// one pass over all waves, then advance every phase
	task automatic model_eval();
		int h;
		int s;
		int y;
		int mag;
		logic q1;
		logic q0;
		logic sharp_now;
		logic [3:0] folded;
		h = 512;
		s = 0;
		for (int i = 0; i < NUM_WAVES; i++) begin
			q1 = m_phase[i][15];
			q0 = m_phase[i][14];
			sharp_now = m_mode.sharp && (!m_mode.semi_sharp || q1);
			folded = m_phase[i][13:10];
			if (q0 ^ sharp_now)
				folded = ~folded;
			mag = sine_entry(folded);
			if (q1 ^ sharp_now)
				mag = 63 - mag;
			// q1 is the sign bit of the 7-bit sample
			y = q1 ? mag - 64 : mag;
			h = h + (y >>> i);
			s = s + (3 - int'(folded[3:2]));
			m_phase[i] = m_phase[i] + {{4{m_dphase[i][11]}}, m_dphase[i]};
		end
		exp_height = h & 1023;
		exp_shade = s & 15;
	endtask

	function automatic render_pkg::color_t expected_color(input logic [9:0] h,
		input logic [3:0] s);
		render_pkg::color_t c;
		logic [3:0] l;
		logic [2:0] r0;
		l = ~h[9:6];
		r0 = l[3] ? l[2:0] : 3'd0;
		c.g = s[3:1];
		c.r = (r0 < c.g) ? r0 : c.g;
		c.b = ~h[9:7];
		return c;
	endfunction

	// ======================================================================
	// test steps
	// ======================================================================

	// increments go out sign extended, read back zero filled
	task automatic load_registers(input string tag);
		logic [15:0] rd;
		bus_write(bus_pkg::MODE, {14'd0, m_mode});
		for (int i = 0; i < NUM_WAVES; i++) begin
			bus_write(bus_pkg::reg_addr_e'(8 + i), m_phase[i]);
			bus_write(bus_pkg::reg_addr_e'(12 + i), {{4{m_dphase[i][11]}}, m_dphase[i]});
		end
		bus_read(bus_pkg::MODE, rd);
		check_word({tag, " MODE readback"}, {14'd0, m_mode}, rd);
		for (int i = 0; i < NUM_WAVES; i++) begin
			bus_read(bus_pkg::reg_addr_e'(8 + i), rd);
			check_phase($sformatf("%s PHASE%0d readback", tag, i), m_phase[i], rd);
			bus_read(bus_pkg::reg_addr_e'(12 + i), rd);
			check_word($sformatf("%s DPHASE%0d readback", tag, i),
				{4'd0, m_dphase[i]}, rd);
		end
	endtask

	task automatic check_phases(input string tag);
		logic [15:0] rd;
		for (int i = 0; i < NUM_WAVES; i++) begin
			bus_read(bus_pkg::reg_addr_e'(8 + i), rd);
			check_phase($sformatf("%s PHASE%0d after steps", tag, i), m_phase[i], rd);
		end
	endtask

	// optionally pokes a START and a PHASE0 write in while busy
	task automatic run_evaluation(input string tag, input bit busy_writes);
		logic [15:0] rd;
		bus_write(bus_pkg::START, 16'h0);
		if (busy_writes) begin
			bus_write(bus_pkg::START, 16'h0);
			bus_write(bus_pkg::PHASE0, 16'h5a5a);
		end
		wait_idle(rd);
		model_eval();
		exp_count = exp_count + 8'd1;
		check_count({tag, " count"}, exp_count, rd[15:8]);
		check_word({tag, " status flags"}, 16'h0002, rd & 16'h00ff);
		bus_read(bus_pkg::HEIGHT, rd);
		check_height({tag, " height"}, exp_height, rd[9:0]);
		bus_read(bus_pkg::COLOR, rd);
		check_color({tag, " color"}, expected_color(exp_height, exp_shade),
			render_pkg::color_t'(rd[8:0]));
		check_shade({tag, " shade"}, exp_shade, rd[15:12]);
	endtask

	task automatic run_pattern(input string tag, input int steps);
		load_registers(tag);
		for (int k = 0; k < steps; k++)
			run_evaluation($sformatf("%s eval %0d", tag, k), 1'b0);
		check_phases(tag);
	endtask

	// ======================================================================
	// main sequence
	// ======================================================================

	initial begin
		int fd;
		int code;
		int fields;
		int file_patterns;
		string line;
		logic [15:0] rd;
		logic [31:0] rnd;
		logic [15:0] f_mode, f_p0, f_p1, f_p2, f_d0, f_d1, f_d2, f_steps;
		clk = 1'b0;
		reset = 1'b1;
		wb_req = '0;
		exp_count = 8'd0;
		file_patterns = 0;
		seed = 32'hfc2b_9b0f;
		repeat (2) @(posedge clk);
		#1;
		reset = 1'b0;

		// everything reads zero out of reset
		bus_read(bus_pkg::STATUS, rd);
		check_word("reset STATUS", 16'h0, rd);
		bus_read(bus_pkg::MODE, rd);
		check_word("reset MODE", 16'h0, rd);
		for (int i = 0; i < NUM_WAVES; i++) begin
			bus_read(bus_pkg::reg_addr_e'(8 + i), rd);
			check_phase($sformatf("reset PHASE%0d", i), 16'h0, rd);
			bus_read(bus_pkg::reg_addr_e'(12 + i), rd);
			check_word($sformatf("reset DPHASE%0d", i), 16'h0, rd);
		end

		// wave 3 does not exist with three waves
		bus_write(bus_pkg::PHASE3, 16'hbeef);
		bus_write(bus_pkg::DPHASE3, 16'h0123);
		bus_read(bus_pkg::PHASE3, rd);
		check_word("unused PHASE3", 16'h0, rd);
		bus_read(bus_pkg::DPHASE3, rd);
		check_word("unused DPHASE3", 16'h0, rd);

		fd = $fopen("render_patterns.txt", "r");
		if (fd == 0) begin
			report_failure("could not open render_patterns.txt");
		end else begin
			while (!$feof(fd)) begin
				code = $fgets(line, fd);
				fields = $sscanf(line, "%h %h %h %h %h %h %h %h", f_mode,
					f_p0, f_p1, f_p2, f_d0, f_d1, f_d2, f_steps);
				// comment and blank lines give no fields
				if (code > 0 && fields == 8) begin
					m_mode = render_pkg::sine_mode_t'(f_mode[1:0]);
					m_phase[0] = f_p0;
					m_phase[1] = f_p1;
					m_phase[2] = f_p2;
					m_dphase[0] = f_d0[11:0];
					m_dphase[1] = f_d1[11:0];
					m_dphase[2] = f_d2[11:0];
					run_pattern($sformatf("file pattern %0d", file_patterns), f_steps);
					file_patterns++;
				end
			end
			$fclose(fd);
		end

		for (int n = 0; n < RANDOM_LINES; n++) begin
			rnd = $random(seed);
			m_mode = render_pkg::sine_mode_t'(rnd[1:0]);
			for (int i = 0; i < NUM_WAVES; i++) begin
				rnd = $random(seed);
				m_phase[i] = rnd[15:0];
				m_dphase[i] = rnd[27:16];
			end
			rnd = $random(seed);
			run_pattern($sformatf("random pattern %0d", n), 1 + rnd[1:0]);
		end

		// writes during an evaluation must not disturb it
		m_mode = render_pkg::sine_mode_t'(2'b01);
		m_phase[0] = 16'h1357;
		m_phase[1] = 16'h9bdf;
		m_phase[2] = 16'h4826;
		m_dphase[0] = 12'h155;
		m_dphase[1] = 12'hea9;
		m_dphase[2] = 12'h3f0;
		load_registers("busy writes");
		run_evaluation("busy writes", 1'b1);
		check_phases("busy writes");

		if (file_patterns == 0) begin
			report_failure("render_patterns.txt held no pattern lines");
		end else begin
			$display("Test OK");
			$finish;
		end
	end

endmodule

// File: wave_counter.sv
`timescale 1ns/100ps

module wave_counter #(
	parameter int NUM_WAVES = 3
) (
	input  logic clk,
	input  logic reset,
	input  logic clear,
	input  logic step,
	input  logic commit,
	output logic [render_pkg::WAVE_INDEX_BITS-1:0] wave_index,
	output logic last,
	output logic [7:0] eval_count
);

	// wave being evaluated this cycle
	always_ff @(posedge clk) begin
		if (reset || clear) begin
			wave_index <= '0;
		end else if (step) begin
			wave_index <= wave_index + 1'b1;
		end
	end

	assign last = (wave_index == render_pkg::WAVE_INDEX_BITS'(NUM_WAVES - 1));

	// completed evaluations, wraps at 256
	always_ff @(posedge clk) begin
		if (reset) begin
			eval_count <= '0;
		end else if (commit) begin
			eval_count <= eval_count + 8'd1;
		end
	end

endmodule

// File: wave_renderer_top.sv
`timescale 1ns/100ps

module wave_renderer_top #(
	parameter int NUM_WAVES = 3
) (
	input  logic clk,
	input  logic reset,
	input  bus_pkg::wb_req_t wb_req,
	output bus_pkg::wb_rsp_t wb_rsp
);

	// control
	logic start;
	logic busy;
	logic step_en;
	logic commit;
	logic last;
	logic [render_pkg::WAVE_INDEX_BITS-1:0] wave_index;
	logic [7:0] eval_count;

	// host side of the phase bank
	render_pkg::sine_mode_t mode;
	render_pkg::phase_wr_t phase_wr;
	render_pkg::dphase_wr_t dphase_wr;
	render_pkg::phase_t [NUM_WAVES-1:0] phases;
	render_pkg::dphase_t [NUM_WAVES-1:0] dphases;

	// data path
	render_pkg::phase_t curr_phase;
	render_pkg::wave_sample_t sample;
	logic [render_pkg::ZG_BITS-1:0] height;
	logic [render_pkg::SHADE_BITS-1:0] shade;
	render_pkg::color_t color;
	logic result_valid;

	wb_register_file #(.NUM_WAVES(NUM_WAVES)) regs (
		.clk(clk), .reset(reset),
		.wb_req(wb_req), .wb_rsp(wb_rsp),
		.start(start), .mode(mode),
		.phase_wr(phase_wr), .dphase_wr(dphase_wr),
		.phases(phases), .dphases(dphases),
		.busy(busy), .result_valid(result_valid), .eval_count(eval_count),
		.height(height), .shade(shade), .color(color)
	);

	render_sequencer seq (
		.clk(clk), .reset(reset),
		.start(start), .last(last),
		.busy(busy), .step_en(step_en), .commit(commit)
	);

	wave_counter #(.NUM_WAVES(NUM_WAVES)) counter (
		.clk(clk), .reset(reset),
		.clear(start), .step(step_en), .commit(commit),
		.wave_index(wave_index), .last(last), .eval_count(eval_count)
	);

	phase_bank #(.NUM_WAVES(NUM_WAVES)) bank (
		.clk(clk), .reset(reset),
		.phase_wr(phase_wr), .dphase_wr(dphase_wr),
		.wave_index(wave_index), .step_en(step_en),
		.curr_phase(curr_phase), .phases(phases), .dphases(dphases)
	);

	sine_wave_map sine_map (
		.phase(curr_phase), .mode(mode), .sample(sample)
	);

	height_accumulator acc (
		.clk(clk), .reset(reset),
		.sample(sample), .wave_index(wave_index),
		.step_en(step_en), .commit(commit),
		.height(height), .shade(shade), .color(color),
		.result_valid(result_valid)
	);

endmodule

// File: wb_register_file.sv
`timescale 1ns/100ps

module wb_register_file #(
	parameter int NUM_WAVES = 3
) (
	input  logic clk,
	input  logic reset,
	input  bus_pkg::wb_req_t wb_req,
	output bus_pkg::wb_rsp_t wb_rsp,
	output logic start,
	output render_pkg::sine_mode_t mode,
	output render_pkg::phase_wr_t phase_wr,
	output render_pkg::dphase_wr_t dphase_wr,
	input  render_pkg::phase_t [NUM_WAVES-1:0] phases,
	input  render_pkg::dphase_t [NUM_WAVES-1:0] dphases,
	input  logic busy,
	input  logic result_valid,
	input  logic [7:0] eval_count,
	input  logic [render_pkg::ZG_BITS-1:0] height,
	input  logic [render_pkg::SHADE_BITS-1:0] shade,
	input  render_pkg::color_t color
);

	localparam int DAT_BITS = bus_pkg::WB_DAT_BITS;
	localparam int DPH_BITS = render_pkg::DPHASE_BITS;

	bus_pkg::reg_addr_e addr;
	logic [render_pkg::WAVE_INDEX_BITS-1:0] wave_sel;
	logic wave_ok;
	logic access;
	logic wr_access;
	logic wr_wave;
	logic ack;
	logic [DAT_BITS-1:0] dat_r;
	logic [DAT_BITS-1:0] rd_data;
	render_pkg::phase_t phase_rd;
	render_pkg::dphase_t dphase_rd;

	assign addr = bus_pkg::reg_addr_e'(wb_req.adr);
	assign wave_sel = wb_req.adr[render_pkg::WAVE_INDEX_BITS-1:0];
	assign wave_ok = (int'(wave_sel) < NUM_WAVES);

	// a new cycle is seen once, ack closes it on the next edge
	assign access = wb_req.cyc && wb_req.stb && !ack;
	assign wr_access = access && wb_req.we;
	// phase registers are frozen during an evaluation
	assign wr_wave = wr_access && !busy && wave_ok;

	// ======================================================================
	// writes land at the ack edge
	// ======================================================================

	assign phase_wr = '{
		we: wr_wave && (addr inside {bus_pkg::PHASE0, bus_pkg::PHASE1,
			bus_pkg::PHASE2, bus_pkg::PHASE3}),
		wave: wave_sel,
		data: wb_req.dat_w
	};

	assign dphase_wr = '{
		we: wr_wave && (addr inside {bus_pkg::DPHASE0, bus_pkg::DPHASE1,
			bus_pkg::DPHASE2, bus_pkg::DPHASE3}),
		wave: wave_sel,
		data: wb_req.dat_w[DPH_BITS-1:0]
	};

	always_ff @(posedge clk) begin
		if (reset) begin
			ack <= 1'b0;
			start <= 1'b0;
			mode <= '0;
		end else begin
			ack <= access;
			// start while busy is simply acked
			start <= wr_access && addr == bus_pkg::START && !busy;
			if (wr_access && addr == bus_pkg::MODE)
				mode <= render_pkg::sine_mode_t'(wb_req.dat_w[1:0]);
		end
	end

	// ======================================================================
	// read side
	// ======================================================================

	always_comb begin
		phase_rd = '0;
		dphase_rd = '0;
		for (int i = 0; i < NUM_WAVES; i++) begin
			if (wave_sel == i) begin
				phase_rd = phases[i];
				dphase_rd = dphases[i];
			end
		end
	end

	always_comb begin
		case (addr)
			bus_pkg::MODE:
				rd_data = DAT_BITS'(mode);
			// busy, valid, then the count in the high byte
			bus_pkg::STATUS:
				rd_data = {eval_count, 6'b0, result_valid, busy};
			bus_pkg::HEIGHT:
				rd_data = DAT_BITS'(height);
			bus_pkg::COLOR:
				rd_data = {shade, 3'b0, color};
			bus_pkg::PHASE0, bus_pkg::PHASE1, bus_pkg::PHASE2, bus_pkg::PHASE3:
				rd_data = phase_rd;
			// zero filled, not sign extended
			bus_pkg::DPHASE0, bus_pkg::DPHASE1, bus_pkg::DPHASE2, bus_pkg::DPHASE3:
				rd_data = {{(DAT_BITS - DPH_BITS){1'b0}}, dphase_rd};
			default:
				rd_data = '0;
		endcase
	end

	// read data only has to be valid with ack
	always_ff @(posedge clk) begin
		if (access)
			dat_r <= rd_data;
	end

	assign wb_rsp = '{ack: ack, dat_r: dat_r};

endmodule
